// ==== Bender.yml ====
package:
  name: twiddle_update

sources:
  - files:
      - common/twiddle_pkg.sv
      - common/ispr_pkg.sv
      - src/mont_mul.sv
      - src/twiddle_core.sv
      - root_bank/root_bank_ctrl.sv
      - root_bank/root_word.sv
      - root_bank/root_select.sv
      - src/twiddle_update_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/twiddle_update_checker.sv
      - tb/tb_twiddle_update.sv

// ==== common/ispr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register addresses, register access, command strobes and
// per-word write control of the twiddle-factor unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package ispr_pkg;

  typedef enum logic [2:0] {
    ispr_prime      = 3'd0,
    ispr_prime_dash = 3'd1,
    ispr_twiddle    = 3'd2,
    ispr_omega      = 3'd3,
    ispr_psi        = 3'd4,
    ispr_omega_idx  = 3'd5,
    ispr_psi_idx    = 3'd6
  } ispr_addr_e;

  // Address also selects the read data
  typedef struct packed {
    ispr_addr_e          addr;
    twiddle_pkg::bank_t  wdata;
    logic                wr_en;
  } ispr_wr_t;

  // One-cycle strobes, at most one per cycle
  typedef struct packed {
    logic update_twiddle;
    logic invert_twiddle;
    logic set_twiddle_as_psi;
    logic update_omega;
    logic update_psi;
    logic omega_idx_inc;
    logic psi_idx_inc;
  } twiddle_cmd_t;

  typedef struct packed {
    logic omega_we;
    logic psi_we;
    logic from_ispr;
  } word_ctl_t;

endpackage

`default_nettype wire

// ==== common/twiddle_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arithmetic widths and data types of the twiddle-factor unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package twiddle_pkg;

  // Coefficient width
  localparam int unsigned coeff_w = 32;

  // Root words held per bank
  localparam int unsigned num_words = 8;

  // Montgomery shift, R = 2^log_r
  localparam int unsigned log_r = 32;

  // One coefficient modulo q
  typedef logic [coeff_w-1:0] coeff_t;

  // Index into a root bank
  typedef logic [$clog2(num_words)-1:0] word_idx_t;

  // Whole root bank, also the width of a register access
  typedef logic [num_words*coeff_w-1:0] bank_t;

endpackage

`default_nettype wire

// ==== files.f ====
common/twiddle_pkg.sv
common/ispr_pkg.sv
src/mont_mul.sv
src/twiddle_core.sv
root_bank/root_bank_ctrl.sv
root_bank/root_word.sv
root_bank/root_select.sv
src/twiddle_update_top.sv
tb/tb_clock_gen.sv
tb/twiddle_update_checker.sv
tb/tb_twiddle_update.sv

// ==== root_bank/root_bank_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Omega and psi index registers and per-word write enable decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module root_bank_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  ispr_pkg::twiddle_cmd_t cmd_i,
  input  ispr_pkg::ispr_wr_t     ispr_i,
  output twiddle_pkg::word_idx_t omega_idx_o,
  output twiddle_pkg::word_idx_t psi_idx_o,
  output ispr_pkg::word_ctl_t    word_ctl_o [twiddle_pkg::num_words]
);

  import twiddle_pkg::*;
  import ispr_pkg::*;

  word_idx_t omega_idx_q;
  word_idx_t psi_idx_q;
  word_idx_t wdata_idx;
  logic      omega_bank_wr;
  logic      psi_bank_wr;

  assign wdata_idx     = ispr_i.wdata[$bits(word_idx_t)-1:0];
  assign omega_bank_wr = ispr_i.wr_en && ispr_i.addr == ispr_omega;
  assign psi_bank_wr   = ispr_i.wr_en && ispr_i.addr == ispr_psi;

  // Increment wraps modulo num_words through the index width
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      omega_idx_q <= '0;
      psi_idx_q   <= '0;
    end else begin
      if (ispr_i.wr_en && ispr_i.addr == ispr_omega_idx) begin
        omega_idx_q <= wdata_idx;
      end else if (cmd_i.omega_idx_inc) begin
        omega_idx_q <= omega_idx_q + 1'b1;
      end
      if (ispr_i.wr_en && ispr_i.addr == ispr_psi_idx) begin
        psi_idx_q <= wdata_idx;
      end else if (cmd_i.psi_idx_inc) begin
        psi_idx_q <= psi_idx_q + 1'b1;
      end
    end
  end

  // Bank write hits every word, commands only the indexed one
  always_comb begin
    for (int i = 0; i < num_words; i++) begin
      word_ctl_o[i].omega_we  = omega_bank_wr ||
                                (cmd_i.update_omega && omega_idx_q == word_idx_t'(i));
      word_ctl_o[i].psi_we    = psi_bank_wr ||
                                (cmd_i.update_psi && psi_idx_q == word_idx_t'(i));
      word_ctl_o[i].from_ispr = ispr_i.wr_en;
    end
  end

  assign omega_idx_o = omega_idx_q;
  assign psi_idx_o   = psi_idx_q;

endmodule

`default_nettype wire

// ==== root_bank/root_select.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Indexed omega/psi word selection and the register read mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module root_select (
  input  ispr_pkg::ispr_addr_e   addr_i,
  input  twiddle_pkg::bank_t     omega_words_i,
  input  twiddle_pkg::bank_t     psi_words_i,
  input  twiddle_pkg::word_idx_t omega_idx_i,
  input  twiddle_pkg::word_idx_t psi_idx_i,
  input  twiddle_pkg::coeff_t    prime_i,
  input  twiddle_pkg::coeff_t    prime_dash_i,
  input  twiddle_pkg::coeff_t    twiddle_i,
  output twiddle_pkg::coeff_t    omega_sel_o,
  output twiddle_pkg::coeff_t    psi_sel_o,
  output twiddle_pkg::bank_t     rdata_o
);

  import twiddle_pkg::*;
  import ispr_pkg::*;

  // Word selected by the current indices
  assign omega_sel_o = omega_words_i[omega_idx_i*coeff_w +: coeff_w];
  assign psi_sel_o   = psi_words_i[psi_idx_i*coeff_w +: coeff_w];

  // Scalars and indices come back zero-extended
  always_comb begin
    unique case (addr_i)
      ispr_prime: begin
        rdata_o = bank_t'(prime_i);
      end
      ispr_prime_dash: begin
        rdata_o = bank_t'(prime_dash_i);
      end
      ispr_twiddle: begin
        rdata_o = bank_t'(twiddle_i);
      end
      ispr_omega: begin
        rdata_o = omega_words_i;
      end
      ispr_psi: begin
        rdata_o = psi_words_i;
      end
      ispr_omega_idx: begin
        rdata_o = bank_t'(omega_idx_i);
      end
      ispr_psi_idx: begin
        rdata_o = bank_t'(psi_idx_i);
      end
      default: begin
        rdata_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== root_bank/root_word.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One omega root word and one psi root word with their load muxes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module root_word (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  ispr_pkg::word_ctl_t  ctl_i,
  input  twiddle_pkg::coeff_t  wdata_i,
  input  twiddle_pkg::coeff_t  omega_sq_i,
  input  twiddle_pkg::coeff_t  omega_sel_i,
  output twiddle_pkg::coeff_t  omega_o,
  output twiddle_pkg::coeff_t  psi_o
);

  import twiddle_pkg::*;

  coeff_t omega_q;
  coeff_t psi_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      omega_q <= '0;
      psi_q   <= '0;
    end else begin
      if (ctl_i.omega_we) begin
        omega_q <= ctl_i.from_ispr ? wdata_i : omega_sq_i;
      end
      // Psi takes a copy of the selected omega
      if (ctl_i.psi_we) begin
        psi_q <= ctl_i.from_ispr ? wdata_i : omega_sel_i;
      end
    end
  end

  assign omega_o = omega_q;
  assign psi_o   = psi_q;

endmodule

`default_nettype wire

// ==== src/mont_mul.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational Montgomery multiplier modulo q, R = 2^32
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module mont_mul (
  input  twiddle_pkg::coeff_t a_i,
  input  twiddle_pkg::coeff_t b_i,
  input  twiddle_pkg::coeff_t q_i,
  input  twiddle_pkg::coeff_t q_dash_i,
  output twiddle_pkg::coeff_t res_o
);

  import twiddle_pkg::*;

  logic [2*coeff_w-1:0] prod;
  coeff_t               m;
  logic [2*coeff_w:0]   sum;
  logic [coeff_w:0]     u;
  logic [coeff_w:0]     u_sub;

  // Full product a*b
  assign prod = a_i * b_i;

  // m = (t mod R) * q' mod R
  assign m = prod[log_r-1:0] * q_dash_i;

  // Low half of t + m*q is zero, so the shift is exact
  assign sum = {1'b0, prod} + m * q_i;
  assign u   = sum[2*coeff_w:log_r];

  // u < 2q, one conditional subtraction
  assign u_sub = u - {1'b0, q_i};
  assign res_o = (u >= {1'b0, q_i}) ? u_sub[coeff_w-1:0] : u[coeff_w-1:0];

endmodule

`default_nettype wire

// ==== src/twiddle_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Prime, prime-dash and twiddle registers with the twiddle update,
// invert and psi-load paths, plus the omega squaring multiplier
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module twiddle_core (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  ispr_pkg::twiddle_cmd_t cmd_i,
  input  ispr_pkg::ispr_wr_t    ispr_i,
  input  twiddle_pkg::coeff_t   omega_sel_i,
  input  twiddle_pkg::coeff_t   psi_sel_i,
  output twiddle_pkg::coeff_t   prime_o,
  output twiddle_pkg::coeff_t   prime_dash_o,
  output twiddle_pkg::coeff_t   twiddle_o,
  output twiddle_pkg::coeff_t   omega_sq_o
);

  import twiddle_pkg::*;
  import ispr_pkg::*;

  coeff_t prime_q;
  coeff_t prime_dash_q;
  coeff_t twiddle_q;
  coeff_t twiddle_mul;
  coeff_t wdata_lo;

  assign wdata_lo = ispr_i.wdata[coeff_w-1:0];

  // twiddle * omega[omega_idx]
  mont_mul u_twiddle_mul (
    .a_i      (twiddle_q),
    .b_i      (omega_sel_i),
    .q_i      (prime_q),
    .q_dash_i (prime_dash_q),
    .res_o    (twiddle_mul)
  );

  // omega[omega_idx] squared
  mont_mul u_omega_sq (
    .a_i      (omega_sel_i),
    .b_i      (omega_sel_i),
    .q_i      (prime_q),
    .q_dash_i (prime_dash_q),
    .res_o    (omega_sq_o)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prime_q      <= '0;
      prime_dash_q <= '0;
      twiddle_q    <= '0;
    end else begin
      if (ispr_i.wr_en && ispr_i.addr == ispr_prime) begin
        prime_q <= wdata_lo;
      end
      if (ispr_i.wr_en && ispr_i.addr == ispr_prime_dash) begin
        prime_dash_q <= wdata_lo;
      end
      // Register write wins over the commands
      if (ispr_i.wr_en && ispr_i.addr == ispr_twiddle) begin
        twiddle_q <= wdata_lo;
      end else if (cmd_i.update_twiddle) begin
        twiddle_q <= twiddle_mul;
      end else if (cmd_i.invert_twiddle) begin
        twiddle_q <= prime_q - twiddle_q;
      end else if (cmd_i.set_twiddle_as_psi) begin
        twiddle_q <= psi_sel_i;
      end
    end
  end

  assign prime_o      = prime_q;
  assign prime_dash_o = prime_dash_q;
  assign twiddle_o    = twiddle_q;

endmodule

`default_nettype wire

// ==== src/twiddle_update_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the twiddle-factor unit: scalar core, root bank
// control, eight root word slices and the read/select mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module twiddle_update_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  ispr_pkg::twiddle_cmd_t cmd_i,
  input  ispr_pkg::ispr_wr_t     ispr_i,
  output twiddle_pkg::bank_t     ispr_rdata_o,
  output twiddle_pkg::coeff_t    twiddle_o,
  output twiddle_pkg::coeff_t    omega_o,
  output twiddle_pkg::coeff_t    psi_o,
  output twiddle_pkg::coeff_t    prime_o,
  output twiddle_pkg::coeff_t    prime_dash_o
);

  import twiddle_pkg::*;
  import ispr_pkg::*;

  coeff_t    omega_sq;
  word_idx_t omega_idx;
  word_idx_t psi_idx;
  word_ctl_t word_ctl [num_words];
  bank_t     omega_words;
  bank_t     psi_words;

  twiddle_core u_core (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cmd_i        (cmd_i),
    .ispr_i       (ispr_i),
    .omega_sel_i  (omega_o),
    .psi_sel_i    (psi_o),
    .prime_o      (prime_o),
    .prime_dash_o (prime_dash_o),
    .twiddle_o    (twiddle_o),
    .omega_sq_o   (omega_sq)
  );

  root_bank_ctrl u_bank_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_i       (cmd_i),
    .ispr_i      (ispr_i),
    .omega_idx_o (omega_idx),
    .psi_idx_o   (psi_idx),
    .word_ctl_o  (word_ctl)
  );

  for (genvar i = 0; i < num_words; i++) begin : g_word
    root_word u_word (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ctl_i       (word_ctl[i]),
      .wdata_i     (ispr_i.wdata[i*coeff_w +: coeff_w]),
      .omega_sq_i  (omega_sq),
      .omega_sel_i (omega_o),
      .omega_o     (omega_words[i*coeff_w +: coeff_w]),
      .psi_o       (psi_words[i*coeff_w +: coeff_w])
    );
  end

  root_select u_select (
    .addr_i        (ispr_i.addr),
    .omega_words_i (omega_words),
    .psi_words_i   (psi_words),
    .omega_idx_i   (omega_idx),
    .psi_idx_i     (psi_idx),
    .prime_i       (prime_o),
    .prime_dash_i  (prime_dash_o),
    .twiddle_i     (twiddle_o),
    .omega_sel_o   (omega_o),
    .psi_sel_o     (psi_o),
    .rdata_o       (ispr_rdata_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and synchronous reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned period_ns  = 8,
  parameter int unsigned rst_cycles = 16
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_o = 1'b1;
    repeat (rst_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/tb_twiddle_update.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Twiddle unit testbench: stimulus, shadow model, compare process
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tb_twiddle_update;

  import twiddle_pkg::*;
  import ispr_pkg::*;

  logic         clk;
  logic         rst;
  twiddle_cmd_t cmd;
  ispr_wr_t     ispr;
  bank_t        rdata;
  coeff_t       twiddle;
  coeff_t       omega;
  coeff_t       psi;
  coeff_t       prime;
  coeff_t       prime_dash;

  // Shadow model of the register state
  coeff_t    m_prime;
  coeff_t    m_prime_dash;
  coeff_t    m_twiddle;
  coeff_t    m_omega [num_words];
  coeff_t    m_psi [num_words];
  word_idx_t m_omega_idx;
  word_idx_t m_psi_idx;

  coeff_t q_val;
  coeff_t q_dash;
  coeff_t r_inv;
  int     errors;
  int     checks;
  int     tests;

  tb_clock_gen u_clock_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  twiddle_update_top DUT (
    .clk_i        (clk),
    .rst_i        (rst),
    .cmd_i        (cmd),
    .ispr_i       (ispr),
    .ispr_rdata_o (rdata),
    .twiddle_o    (twiddle),
    .omega_o      (omega),
    .psi_o        (psi),
    .prime_o      (prime),
    .prime_dash_o (prime_dash)
  );

  bind twiddle_update_top twiddle_update_checker u_checker (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cmd_i        (cmd_i),
    .ispr_i       (ispr_i),
    .rdata_i      (ispr_rdata_o),
    .twiddle_i    (twiddle_o),
    .omega_i      (omega_o),
    .psi_i        (psi_o),
    .prime_i      (prime_o),
    .prime_dash_i (prime_dash_o)
  );

  // a*b*R^-1 mod q, reduced through the inverse of R = 2^32 modulo q
  function automatic coeff_t mont_ref(coeff_t a, coeff_t b, coeff_t q, coeff_t rinv);
    logic [63:0] ab;
    ab = (64'(a) * 64'(b)) % 64'(q);
    return coeff_t'((ab * 64'(rinv)) % 64'(q));
  endfunction

  // Inverse of 2^32 modulo q by search
  function automatic coeff_t r_inverse(coeff_t q);
    logic [63:0] r_mod;
    coeff_t      inv;
    r_mod = (64'd1 << log_r) % 64'(q);
    inv   = '0;
    for (int unsigned x = 1; x < q; x++) begin
      if ((r_mod * 64'(x)) % 64'(q) == 64'd1) begin
        inv = coeff_t'(x);
      end
    end
    return inv;
  endfunction

  // Newton steps for q^-1 mod 2^32, then negate
  function automatic coeff_t neg_inverse(coeff_t q);
    coeff_t x;
    x = q;
    for (int i = 0; i < 5; i++) begin
      x = x * (32'd2 - q * x);
    end
    return -x;
  endfunction

  function automatic bank_t model_read(ispr_addr_e addr);
    bank_t r;
    r = '0;
    case (addr)
      ispr_prime:      r = bank_t'(m_prime);
      ispr_prime_dash: r = bank_t'(m_prime_dash);
      ispr_twiddle:    r = bank_t'(m_twiddle);
      ispr_omega_idx:  r = bank_t'(m_omega_idx);
      ispr_psi_idx:    r = bank_t'(m_psi_idx);
      ispr_omega: begin
        for (int i = 0; i < num_words; i++) r[i*coeff_w +: coeff_w] = m_omega[i];
      end
      ispr_psi: begin
        for (int i = 0; i < num_words; i++) r[i*coeff_w +: coeff_w] = m_psi[i];
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic bank_t random_bank(bit reduced);
    bank_t b;
    for (int i = 0; i < num_words; i++) begin
      b[i*coeff_w +: coeff_w] = reduced ? $urandom_range(q_val - 1) : $urandom();
    end
    return b;
  endfunction

  task automatic check_coeff(string name, coeff_t got, coeff_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bank(string name, bank_t got, bank_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Compare outputs before the edge, then advance the model
  always @(posedge clk) begin : compare_model
    coeff_t sel_omega;
    coeff_t sel_psi;
    if (rst) begin
      m_prime      = '0;
      m_prime_dash = '0;
      m_twiddle    = '0;
      m_omega_idx  = '0;
      m_psi_idx    = '0;
      for (int i = 0; i < num_words; i++) begin
        m_omega[i] = '0;
        m_psi[i]   = '0;
      end
    end else begin
      sel_omega = m_omega[m_omega_idx];
      sel_psi   = m_psi[m_psi_idx];
      check_coeff("twiddle_o", twiddle, m_twiddle);
      check_coeff("omega_o", omega, sel_omega);
      check_coeff("psi_o", psi, sel_psi);
      check_coeff("prime_o", prime, m_prime);
      check_coeff("prime_dash_o", prime_dash, m_prime_dash);
      check_bank("ispr_rdata_o", rdata, model_read(ispr.addr));
      if (ispr.wr_en) begin
        case (ispr.addr)
          ispr_prime:      m_prime      = ispr.wdata[coeff_w-1:0];
          ispr_prime_dash: m_prime_dash = ispr.wdata[coeff_w-1:0];
          ispr_twiddle:    m_twiddle    = ispr.wdata[coeff_w-1:0];
          ispr_omega_idx:  m_omega_idx  = ispr.wdata[2:0];
          ispr_psi_idx:    m_psi_idx    = ispr.wdata[2:0];
          ispr_omega: begin
            for (int i = 0; i < num_words; i++) m_omega[i] = ispr.wdata[i*coeff_w +: coeff_w];
          end
          ispr_psi: begin
            for (int i = 0; i < num_words; i++) m_psi[i] = ispr.wdata[i*coeff_w +: coeff_w];
          end
          default: ;
        endcase
      end else if (cmd.update_twiddle) begin
        m_twiddle = mont_ref(m_twiddle, sel_omega, m_prime, r_inv);
      end else if (cmd.invert_twiddle) begin
        m_twiddle = m_prime - m_twiddle;
      end else if (cmd.set_twiddle_as_psi) begin
        m_twiddle = sel_psi;
      end else if (cmd.update_omega) begin
        m_omega[m_omega_idx] = mont_ref(sel_omega, sel_omega, m_prime, r_inv);
      end else if (cmd.update_psi) begin
        m_psi[m_psi_idx] = sel_omega;
      end else if (cmd.omega_idx_inc) begin
        m_omega_idx = m_omega_idx + 3'd1;
      end else if (cmd.psi_idx_inc) begin
        m_psi_idx = m_psi_idx + 3'd1;
      end
    end
  end

  task automatic write_reg(ispr_addr_e addr, bank_t data);
    @(negedge clk);
    cmd        = '0;
    ispr.addr  = addr;
    ispr.wdata = data;
    ispr.wr_en = 1'b1;
  endtask

  // Strobe or idle cycle with random write data that must be ignored
  task automatic issue_cmd(twiddle_cmd_t c, ispr_addr_e addr);
    @(negedge clk);
    cmd        = c;
    ispr.addr  = addr;
    ispr.wdata = random_bank(1'b0);
    ispr.wr_en = 1'b0;
  endtask

  task automatic load_field();
    write_reg(ispr_prime, bank_t'(q_val));
    write_reg(ispr_prime_dash, bank_t'(q_dash));
    write_reg(ispr_twiddle, random_bank(1'b1));
    write_reg(ispr_omega, random_bank(1'b1));
    write_reg(ispr_psi, random_bank(1'b1));
    write_reg(ispr_omega_idx, '0);
    write_reg(ispr_psi_idx, '0);
  endtask

  task automatic finish_test(string name, int errors_before);
    issue_cmd('0, ispr_twiddle);
    @(negedge clk);
    tests++;
    $display("Test %0d %s: %s (%0d mismatches)", tests, name,
             (errors == errors_before) ? "ok" : "failed", errors - errors_before);
  endtask

  task automatic wait_reset_release(output bit released);
    int n;
    n = 0;
    @(negedge clk);
    while (rst !== 1'b0 && n < 100) begin
      @(negedge clk);
      n++;
    end
    released = (rst === 1'b0);
  endtask

  task automatic run_tests();
    twiddle_cmd_t c;
    int           e;
    int unsigned  r;
    e = errors;
    for (int a = 0; a < 7; a++) issue_cmd('0, ispr_addr_e'(a));
    for (int k = 0; k < 2; k++) begin
      for (int a = 0; a < 7; a++) begin
        write_reg(ispr_addr_e'(a), random_bank(1'b0));
        issue_cmd('0, ispr_addr_e'(a));
      end
    end
    finish_test("reset and readback", e);
    e = errors;
    load_field();
    c = '0;
    c.update_twiddle = 1'b1;
    for (int k = 0; k < num_words; k++) begin
      write_reg(ispr_omega_idx, bank_t'(k));
      issue_cmd(c, ispr_twiddle);
      issue_cmd(c, ispr_twiddle);
    end
    finish_test("update twiddle", e);
    e = errors;
    for (int k = 0; k < 10; k++) begin
      c = '0;
      c.update_omega = 1'b1;
      issue_cmd(c, ispr_omega);
      c = '0;
      c.omega_idx_inc = 1'b1;
      issue_cmd(c, ispr_omega_idx);
      issue_cmd('0, ispr_omega_idx);
      c = '0;
      c.psi_idx_inc = 1'b1;
      issue_cmd(c, ispr_psi_idx);
    end
    finish_test("update omega and index wrap", e);
    e = errors;
    for (int k = 0; k < num_words; k++) begin
      c = '0;
      c.update_psi = 1'b1;
      issue_cmd(c, ispr_psi);
      c = '0;
      c.set_twiddle_as_psi = 1'b1;
      issue_cmd(c, ispr_twiddle);
      c = '0;
      c.omega_idx_inc = 1'b1;
      issue_cmd(c, ispr_psi);
      c = '0;
      c.psi_idx_inc = 1'b1;
      issue_cmd(c, ispr_psi);
    end
    finish_test("update psi and set twiddle", e);
    e = errors;
    c = '0;
    c.invert_twiddle = 1'b1;
    write_reg(ispr_twiddle, '0);
    issue_cmd(c, ispr_twiddle);
    for (int k = 0; k < 4; k++) begin
      write_reg(ispr_twiddle, bank_t'($urandom()));
      issue_cmd(c, ispr_twiddle);
      issue_cmd(c, ispr_twiddle);
    end
    finish_test("invert twiddle", e);
    e = errors;
    load_field();
    for (int k = 0; k < 200; k++) begin
      r = $urandom_range(8);
      if (r < 7) begin
        issue_cmd(twiddle_cmd_t'(7'd1 << r), ispr_addr_e'($urandom_range(6)));
      end else if (r == 7) begin
        write_reg(ispr_addr_e'($urandom_range(6, 2)), random_bank(1'b1));
      end else begin
        issue_cmd('0, ispr_addr_e'($urandom_range(6)));
      end
    end
    finish_test("random sequence", e);
  endtask

  initial begin : stimulus
    bit released;
    void'($urandom(32'hd6cb_bbe2));
    cmd    = '0;
    ispr   = '0;
    errors = 0;
    checks = 0;
    tests  = 0;
    q_val  = 32'd3329;
    q_dash = neg_inverse(q_val);
    r_inv  = r_inverse(q_val);
    wait_reset_release(released);
    if (!released) begin
      $display("Reset was still asserted after 100 cycles");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      run_tests();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb/twiddle_update_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the twiddle unit top-level ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module twiddle_update_checker (
  input logic                   clk_i,
  input logic                   rst_i,
  input ispr_pkg::twiddle_cmd_t cmd_i,
  input ispr_pkg::ispr_wr_t     ispr_i,
  input twiddle_pkg::bank_t     rdata_i,
  input twiddle_pkg::coeff_t    twiddle_i,
  input twiddle_pkg::coeff_t    omega_i,
  input twiddle_pkg::coeff_t    psi_i,
  input twiddle_pkg::coeff_t    prime_i,
  input twiddle_pkg::coeff_t    prime_dash_i
);

  import ispr_pkg::*;

  logic [$bits(twiddle_cmd_t)-1:0] cmd_bits;

  assign cmd_bits = cmd_i;

  strobes_onehot0: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(cmd_bits))
    else $error("More than one command strobe in one cycle");

  // Read-back index steps by one and wraps 7 to 0
  omega_idx_wraps: assert property (@(posedge clk_i) disable iff (rst_i)
    (cmd_i.omega_idx_inc && !ispr_i.wr_en && ispr_i.addr == ispr_omega_idx) ##1
    (ispr_i.addr == ispr_omega_idx)
    |-> rdata_i[2:0] == $past(rdata_i[2:0]) + 3'd1)
    else $error("Omega index did not advance modulo 8");

  outputs_zero_after_reset: assert property (@(posedge clk_i)
    $fell(rst_i) |-> (twiddle_i == '0 && omega_i == '0 && psi_i == '0 &&
                      prime_i == '0 && prime_dash_i == '0 && rdata_i == '0))
    else $error("Outputs not zero after reset");

endmodule

`default_nettype wire
